// File: verilog/fpu_defs_pkg.sv
// Shared sizes, encodings and bundles of the float/integer conversion unit
// Single precision only; no unsigned or double formats
// FIFO_DEPTH and RES_CREDITS also size the counters below

package fpu_defs_pkg;

   ////////////////////////////////////////
   // Number format
   ////////////////////////////////////////

   // Integer word width
   localparam int C_OP = 32;
   // Exponent and stored mantissa widths
   localparam int C_EXP = 8;
   localparam int C_MANT = 23;
   localparam int C_BIAS = 127;
   // Exponent at which the mantissa LSB has integer weight one
   localparam int C_SHIFT_BIAS = C_BIAS + C_MANT;
   // Signed shift amount, one bit above the exponent
   localparam int C_EXP_SHIFT = C_EXP + 1;

   // Saturation values for ftoi overflow
   localparam logic [C_OP-1:0] C_INF = 32'h7FFF_FFFF;
   localparam logic [C_OP-1:0] C_MINF = 32'h8000_0000;

   ////////////////////////////////////////
   // Flow control
   ////////////////////////////////////////

   localparam int FIFO_DEPTH = 4;
   localparam int RES_CREDITS = 2;

   // Queue pointer and occupancy widths
   localparam int C_PTR_W = $clog2(FIFO_DEPTH);
   localparam int C_CNT_W = $clog2(FIFO_DEPTH + 1);
   // Result credit counter width
   localparam int C_CRED_W = $clog2(RES_CREDITS + 1);

   ////////////////////////////////////////
   // Types
   ////////////////////////////////////////

   typedef enum logic {
      op_ftoi = 1'b0,
      op_itof = 1'b1
   } fpu_op_e;

   // itof rounding, nearest-even or toward zero
   typedef enum logic {
      rm_rne = 1'b0,
      rm_rtz = 1'b1
   } fpu_rm_e;

   typedef struct packed {
      logic nv;    // invalid
      logic of;    // overflow
      logic zero;  // result zero
      logic ix;    // inexact
   } fpu_flags_t;

   typedef struct packed {
      fpu_op_e op;
      logic [C_OP-1:0] operand;
   } fpu_req_t;

   typedef struct packed {
      logic [C_OP-1:0] result;
      fpu_flags_t flags;
   } fpu_res_t;

endpackage

// File: verilog/fpu_ftoi.sv
// Float to signed integer, truncating toward zero
// Mantissa arrives with the hidden bit already set by the caller
// Overflow, infinity and NaN saturate by sign; NaN also flags invalid

`timescale 1ns/10ps

module fpu_ftoi (
   input  logic                               sign,
   input  logic [fpu_defs_pkg::C_EXP-1:0]     exp,
   input  logic [fpu_defs_pkg::C_MANT:0]      mant,
   output logic [fpu_defs_pkg::C_OP-1:0]      result,
   output fpu_defs_pkg::fpu_flags_t           flags
);

   // Scale of the 24-bit integer significand
   logic signed [fpu_defs_pkg::C_EXP_SHIFT-1:0] int_shift;
   // Left shift into the frame with C_MANT fraction bits
   logic signed [fpu_defs_pkg::C_EXP_SHIFT-1:0] shift_amount;
   logic                                        shift_neg;
   logic [fpu_defs_pkg::C_MANT+fpu_defs_pkg::C_OP-2:0] mant_ext;
   // 31 integer bits above 23 fraction bits
   logic [fpu_defs_pkg::C_MANT+fpu_defs_pkg::C_OP-2:0] temp_shift;
   logic [fpu_defs_pkg::C_OP-2:0]               int_part;
   logic [fpu_defs_pkg::C_OP-1:0]               twos;
   logic                                        overflow;
   logic                                        input_zero;

   ////////////////////////////////////////
   // Shift
   ////////////////////////////////////////

   assign int_shift = $signed({1'b0, exp})
                    - $signed((fpu_defs_pkg::C_EXP_SHIFT)'(fpu_defs_pkg::C_SHIFT_BIAS));
   assign shift_amount = int_shift
                       + $signed((fpu_defs_pkg::C_EXP_SHIFT)'(fpu_defs_pkg::C_MANT));
   // Negative means magnitude below one
   assign shift_neg = shift_amount[fpu_defs_pkg::C_EXP_SHIFT-1];

   assign mant_ext = {{(fpu_defs_pkg::C_OP-2){1'b0}}, mant};
   assign temp_shift = shift_neg ? '0
                     : (mant_ext << shift_amount[fpu_defs_pkg::C_EXP_SHIFT-2:0]);

   // Fraction bits dropped here, i.e. truncation
   assign int_part = temp_shift[fpu_defs_pkg::C_MANT+fpu_defs_pkg::C_OP-2:fpu_defs_pkg::C_MANT];
   assign twos = ~{1'b0, int_part} + (fpu_defs_pkg::C_OP)'(1);

   ////////////////////////////////////////
   // Result and flags
   ////////////////////////////////////////

   // Leading one above bit 30 does not fit
   assign overflow = shift_amount
                   > $signed((fpu_defs_pkg::C_EXP_SHIFT)'(fpu_defs_pkg::C_OP - 2));

   always_comb begin
      if (overflow) begin
         result = sign ? fpu_defs_pkg::C_MINF : fpu_defs_pkg::C_INF;
      end else if (sign) begin
         result = twos;
      end else begin
         result = {1'b0, int_part};
      end
   end

   assign input_zero = ~|{exp, mant};

   assign flags.of = overflow;
   assign flags.zero = ~|result & ~overflow;
   // Lost fraction, sub-one value or saturation
   assign flags.ix = (|temp_shift[fpu_defs_pkg::C_MANT-1:0] | shift_neg | overflow)
                   & ~input_zero;
   // NaN only, infinity is a plain overflow
   assign flags.nv = (&exp) & (|mant[fpu_defs_pkg::C_MANT-1:0]);

endmodule

// File: verilog/fpu_itof.sv
// Signed integer to single-precision float
// Rounds to nearest-even or toward zero per rm
// Exponent never overflows for a 32-bit source, so nv and of stay low

`timescale 1ns/10ps

module fpu_itof (
   input  logic [fpu_defs_pkg::C_OP-1:0]  operand,
   input  fpu_defs_pkg::fpu_rm_e          rm,
   output logic [fpu_defs_pkg::C_OP-1:0]  result,
   output fpu_defs_pkg::fpu_flags_t       flags
);

   logic                                  sign;
   logic [fpu_defs_pkg::C_OP-1:0]         mag;
   // Leading zero count, sized to the exponent
   logic [fpu_defs_pkg::C_EXP-1:0]        lz;
   logic [fpu_defs_pkg::C_OP-1:0]         norm;
   logic [fpu_defs_pkg::C_MANT:0]         sig;
   logic                                  guard;
   logic                                  sticky;
   logic                                  round_up;
   logic [fpu_defs_pkg::C_MANT+1:0]       sig_rnd;
   logic                                  carry;
   logic [fpu_defs_pkg::C_EXP-1:0]        exp_pre;
   logic [fpu_defs_pkg::C_EXP-1:0]        exp_res;
   logic [fpu_defs_pkg::C_MANT-1:0]       mant_res;
   logic                                  operand_zero;

   ////////////////////////////////////////
   // Magnitude and normalize
   ////////////////////////////////////////

   assign sign = operand[fpu_defs_pkg::C_OP-1];
   // Most negative value maps onto itself and stays correct as unsigned
   assign mag = sign ? (~operand + (fpu_defs_pkg::C_OP)'(1)) : operand;
   assign operand_zero = ~|operand;

   // Highest set bit wins
   always_comb begin
      lz = '0;
      for (int i = 0; i < fpu_defs_pkg::C_OP; i++) begin
         if (mag[i]) begin
            lz = (fpu_defs_pkg::C_EXP)'(fpu_defs_pkg::C_OP - 1 - i);
         end
      end
   end

   // Leading one now in bit 31
   assign norm = mag << lz;

   ////////////////////////////////////////
   // Round
   ////////////////////////////////////////

   // 24-bit significand with guard and sticky below it
   assign sig = norm[fpu_defs_pkg::C_OP-1:fpu_defs_pkg::C_OP-1-fpu_defs_pkg::C_MANT];
   assign guard = norm[fpu_defs_pkg::C_OP-2-fpu_defs_pkg::C_MANT];
   assign sticky = |norm[fpu_defs_pkg::C_OP-3-fpu_defs_pkg::C_MANT:0];

   // Ties go to the even significand
   assign round_up = (rm == fpu_defs_pkg::rm_rne) & guard & (sticky | sig[0]);
   assign sig_rnd = {1'b0, sig} + (fpu_defs_pkg::C_MANT + 2)'(round_up);
   assign carry = sig_rnd[fpu_defs_pkg::C_MANT+1];

   // Leading one at bit 31 gives bias plus 31
   assign exp_pre = (fpu_defs_pkg::C_EXP)'(fpu_defs_pkg::C_SHIFT_BIAS + fpu_defs_pkg::C_OP
                                            - 1 - fpu_defs_pkg::C_MANT) - lz;
   assign exp_res = exp_pre + (fpu_defs_pkg::C_EXP)'(carry);

   // Carry out leaves an all-zero fraction
   assign mant_res = sig_rnd[fpu_defs_pkg::C_MANT-1:0];

   ////////////////////////////////////////
   // Output
   ////////////////////////////////////////

   assign result = operand_zero ? '0 : {sign, exp_res, mant_res};

   assign flags.nv = 1'b0;
   assign flags.of = 1'b0;
   assign flags.zero = operand_zero;
   // Any dropped bit in either mode
   assign flags.ix = guard | sticky;

endmodule

// File: verilog/fpu_req_fifo.sv
// Request queue of FIFO_DEPTH entries
// No overflow check; the sender's credit count keeps push within space
// Pop on an empty queue is ignored

`timescale 1ns/10ps

module fpu_req_fifo (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   push,
   input  fpu_defs_pkg::fpu_req_t push_data,
   input  logic                   pop,
   output fpu_defs_pkg::fpu_req_t head,
   output logic                   empty,
   output logic                   credit
);

   fpu_defs_pkg::fpu_req_t             mem [fpu_defs_pkg::FIFO_DEPTH];
   logic [fpu_defs_pkg::C_PTR_W-1:0]   rd_ptr;
   logic [fpu_defs_pkg::C_PTR_W-1:0]   wr_ptr;
   logic [fpu_defs_pkg::C_CNT_W-1:0]   count;
   logic                               pop_ok;

   assign empty = (count == '0);
   assign pop_ok = pop & ~empty;
   assign head = mem[rd_ptr];

   // Storage, no reset
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // Pointers wrap at the last entry
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == (fpu_defs_pkg::C_PTR_W)'(fpu_defs_pkg::FIFO_DEPTH - 1))
                      ? '0 : wr_ptr + (fpu_defs_pkg::C_PTR_W)'(1);
         end
         if (pop_ok) begin
            rd_ptr <= (rd_ptr == (fpu_defs_pkg::C_PTR_W)'(fpu_defs_pkg::FIFO_DEPTH - 1))
                      ? '0 : rd_ptr + (fpu_defs_pkg::C_PTR_W)'(1);
         end
      end
   end

   // Occupancy, and the credit pulse one cycle after each pop
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
         credit <= 1'b0;
      end else begin
         credit <= pop_ok;
         case ({push, pop_ok})
            2'b10: count <= count + (fpu_defs_pkg::C_CNT_W)'(1);
            2'b01: count <= count - (fpu_defs_pkg::C_CNT_W)'(1);
            default: count <= count;
         endcase
      end
   end

endmodule

// File: verilog/fpu_cfg_regs.sv
// Rounding mode and sticky exception flags
// Mode defaults to nearest-even; a write shows on the next pop
// Clear beats accumulation in the same cycle

`timescale 1ns/10ps

module fpu_cfg_regs (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     cfg_write,
   input  fpu_defs_pkg::fpu_rm_e    cfg_rm,
   input  logic                     flags_clear,
   input  logic                     acc,
   input  fpu_defs_pkg::fpu_flags_t acc_flags,
   output fpu_defs_pkg::fpu_rm_e    rm,
   output fpu_defs_pkg::fpu_flags_t flags_sticky
);

   ////////////////////////////////////////
   // Rounding mode
   ////////////////////////////////////////

   // Steers fpu_itof only
   always_ff @(posedge clk) begin
      if (reset) begin
         rm <= fpu_defs_pkg::rm_rne;
      end else if (cfg_write) begin
         rm <= cfg_rm;
      end
   end

   ////////////////////////////////////////
   // Sticky flags
   ////////////////////////////////////////

   // OR in the flags of every issued result
   always_ff @(posedge clk) begin
      if (reset) begin
         flags_sticky <= '0;
      end else if (flags_clear) begin
         flags_sticky <= '0;
      end else if (acc) begin
         flags_sticky <= fpu_defs_pkg::fpu_flags_t'(flags_sticky | acc_flags);
      end
   end

endmodule

// File: verilog/fpu_conv_pipe.sv
// Dispatch of the queue head to ftoi or itof, one result register
// Pops only with a result credit in hand; res_valid is a one-cycle pulse
// Result credits start at RES_CREDITS and come back via res_credit

`timescale 1ns/10ps

module fpu_conv_pipe (
   input  logic                     clk,
   input  logic                     reset,
   input  fpu_defs_pkg::fpu_req_t   head,
   input  logic                     empty,
   input  logic                     res_credit,
   input  fpu_defs_pkg::fpu_rm_e    rm,
   output logic                     pop,
   output logic                     res_valid,
   output fpu_defs_pkg::fpu_res_t   res,
   output logic                     acc,
   output fpu_defs_pkg::fpu_flags_t acc_flags
);

   logic                               op_sign;
   logic [fpu_defs_pkg::C_EXP-1:0]     op_exp;
   logic [fpu_defs_pkg::C_MANT:0]      op_mant;
   logic [fpu_defs_pkg::C_OP-1:0]      ftoi_result;
   logic [fpu_defs_pkg::C_OP-1:0]      itof_result;
   fpu_defs_pkg::fpu_flags_t           ftoi_flags;
   fpu_defs_pkg::fpu_flags_t           itof_flags;
   fpu_defs_pkg::fpu_res_t             res_next;
   logic [fpu_defs_pkg::C_CRED_W-1:0]  credits;

   ////////////////////////////////////////
   // Unpack and convert
   ////////////////////////////////////////

   assign op_sign = head.operand[fpu_defs_pkg::C_OP-1];
   assign op_exp = head.operand[fpu_defs_pkg::C_OP-2 -: fpu_defs_pkg::C_EXP];
   // Hidden bit only for a nonzero exponent
   assign op_mant = {|op_exp, head.operand[fpu_defs_pkg::C_MANT-1:0]};

   fpu_ftoi fpu_ftoi_i (
      .sign   (op_sign),
      .exp    (op_exp),
      .mant   (op_mant),
      .result (ftoi_result),
      .flags  (ftoi_flags)
   );

   fpu_itof fpu_itof_i (
      .operand (head.operand),
      .rm      (rm),
      .result  (itof_result),
      .flags   (itof_flags)
   );

   always_comb begin
      res_next = '0;
      case (head.op)
         fpu_defs_pkg::op_ftoi: begin
            res_next.result = ftoi_result;
            res_next.flags = ftoi_flags;
         end
         fpu_defs_pkg::op_itof: begin
            res_next.result = itof_result;
            res_next.flags = itof_flags;
         end
      endcase
   end

   ////////////////////////////////////////
   // Result credits and issue
   ////////////////////////////////////////

   assign pop = ~empty & (credits != '0);

   // Spend on pop, regain on res_credit; both at once cancel
   always_ff @(posedge clk) begin
      if (reset) begin
         credits <= (fpu_defs_pkg::C_CRED_W)'(fpu_defs_pkg::RES_CREDITS);
      end else begin
         case ({pop, res_credit})
            2'b10: credits <= credits - (fpu_defs_pkg::C_CRED_W)'(1);
            2'b01: credits <= credits + (fpu_defs_pkg::C_CRED_W)'(1);
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         res_valid <= 1'b0;
      end else begin
         res_valid <= pop;
      end
   end

   // Payload held until the next pop
   always_ff @(posedge clk) begin
      if (pop) begin
         res <= res_next;
      end
   end

   // Sticky update straight from the result register
   assign acc = res_valid;
   assign acc_flags = res.flags;

endmodule

// File: verilog/fpu_conv_top.sv
// Conversion unit top, request queue plus pipe plus config block
// Sender starts with FIFO_DEPTH request credits
// Receiver owes one res_credit pulse per consumed result

`timescale 1ns/10ps

module fpu_conv_top (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     req_valid,
   input  fpu_defs_pkg::fpu_req_t   req,
   output logic                     req_credit,
   output logic                     res_valid,
   output fpu_defs_pkg::fpu_res_t   res,
   input  logic                     res_credit,
   input  logic                     cfg_write,
   input  fpu_defs_pkg::fpu_rm_e    cfg_rm,
   input  logic                     flags_clear,
   output fpu_defs_pkg::fpu_flags_t flags_sticky
);

   fpu_defs_pkg::fpu_req_t    head;
   logic                      empty;
   logic                      pop;
   fpu_defs_pkg::fpu_rm_e     rm;
   logic                      acc;
   fpu_defs_pkg::fpu_flags_t  acc_flags;

   // Every req_valid is a push
   fpu_req_fifo fpu_req_fifo_i (
      .clk       (clk),
      .reset     (reset),
      .push      (req_valid),
      .push_data (req),
      .pop       (pop),
      .head      (head),
      .empty     (empty),
      .credit    (req_credit)
   );

   fpu_conv_pipe fpu_conv_pipe_i (
      .clk        (clk),
      .reset      (reset),
      .head       (head),
      .empty      (empty),
      .res_credit (res_credit),
      .rm         (rm),
      .pop        (pop),
      .res_valid  (res_valid),
      .res        (res),
      .acc        (acc),
      .acc_flags  (acc_flags)
   );

   fpu_cfg_regs fpu_cfg_regs_i (
      .clk          (clk),
      .reset        (reset),
      .cfg_write    (cfg_write),
      .cfg_rm       (cfg_rm),
      .flags_clear  (flags_clear),
      .acc          (acc),
      .acc_flags    (acc_flags),
      .rm           (rm),
      .flags_sticky (flags_sticky)
   );

endmodule

// File: verif/fpu_conv_tb.sv
// Conversion unit testbench with stimulus and expectations from verif/fpu_conv_vectors.txt
// Run from the project root so that the vector path resolves
// Result credits come back after a random delay of 0 to 7 cycles

`timescale 1ns/10ps

module fpu_conv_tb;

   logic                     clk = 1'b0;
   logic                     reset;
   logic                     req_valid;
   fpu_defs_pkg::fpu_req_t   req;
   logic                     req_credit;
   logic                     res_valid;
   fpu_defs_pkg::fpu_res_t   res;
   logic                     res_credit;
   logic                     cfg_write;
   fpu_defs_pkg::fpu_rm_e    cfg_rm;
   logic                     flags_clear;
   fpu_defs_pkg::fpu_flags_t flags_sticky;

   // Vector table with kind 0 for ftoi, 1 for itof and 2 for a mode write
   int          vec_group[$];
   int          vec_kind[$];
   logic [31:0] vec_operand[$];
   logic [31:0] vec_result[$];
   logic [3:0]  vec_flags[$];

   // Expected results in request order
   fpu_defs_pkg::fpu_res_t exp_q[$];
   // Cycle numbers at which res_credit goes back
   int credit_due[$];

   int seed;
   int cycle;
   int sent_count;
   int rcv_count;
   int credit_back;
   int check_count;
   int error_count;
   int group_count;

   always #20 clk = ~clk;

   fpu_conv_top fpu_conv_top_i (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (req_valid),
      .req          (req),
      .req_credit   (req_credit),
      .res_valid    (res_valid),
      .res          (res),
      .res_credit   (res_credit),
      .cfg_write    (cfg_write),
      .cfg_rm       (cfg_rm),
      .flags_clear  (flags_clear),
      .flags_sticky (flags_sticky)
   );

   ////////////////////////////////////////
   // Checking and vector loading
   ////////////////////////////////////////

   task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("FAILED %s: got %h, expected %h", name, got, expected);
      end
   endtask

   task automatic load_vectors(output bit ok);
      int          fd;
      int          n;
      int          grp;
      string       line;
      string       op_str;
      logic [31:0] operand;
      logic [31:0] result;
      logic [3:0]  flags;
      ok = 1'b0;
      fd = $fopen("verif/fpu_conv_vectors.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Skip blank and comment lines
            if (n > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%d %s %h %h %h", grp, op_str, operand, result, flags);
               if (n == 5 && (op_str == "ftoi" || op_str == "itof" || op_str == "rm")) begin
                  vec_group.push_back(grp);
                  vec_kind.push_back((op_str == "ftoi") ? 0 : ((op_str == "itof") ? 1 : 2));
                  vec_operand.push_back(operand);
                  vec_result.push_back(result);
                  vec_flags.push_back(flags);
               end else begin
                  error_count++;
                  $display("Vector line could not be read: %s", line);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   ////////////////////////////////////////
   // Driver side
   ////////////////////////////////////////

   // Inputs change 2 ns after the rising edge
   task automatic next_slot();
      @(posedge clk);
      #2;
      req_valid = 1'b0;
      cfg_write = 1'b0;
      flags_clear = 1'b0;
   endtask

   task automatic send_request(int i);
      fpu_defs_pkg::fpu_res_t expected;
      next_slot();
      // Sender holds FIFO_DEPTH credits at most
      while (sent_count - credit_back >= fpu_defs_pkg::FIFO_DEPTH) begin
         next_slot();
      end
      expected.result = vec_result[i];
      expected.flags = fpu_defs_pkg::fpu_flags_t'(vec_flags[i]);
      exp_q.push_back(expected);
      req.op = (vec_kind[i] == 1) ? fpu_defs_pkg::op_itof : fpu_defs_pkg::op_ftoi;
      req.operand = vec_operand[i];
      req_valid = 1'b1;
      sent_count++;
   endtask

   task automatic wait_idle();
      next_slot();
      wait (rcv_count == sent_count);
   endtask

   // New mode applies to the next pop, so drain first
   task automatic write_mode(logic [31:0] value);
      wait_idle();
      next_slot();
      cfg_rm = value[0] ? fpu_defs_pkg::rm_rtz : fpu_defs_pkg::rm_rne;
      cfg_write = 1'b1;
   endtask

   task automatic finish_group(int grp, int nvec, logic [3:0] flags, int err_start);
      wait_idle();
      // Sticky register settles one edge after the last res_valid
      next_slot();
      check_value("flags_sticky", {28'h0, flags_sticky}, {28'h0, flags});
      flags_clear = 1'b1;
      next_slot();
      check_value("flags_sticky", {28'h0, flags_sticky}, 32'h0);
      group_count++;
      $display("Group %0d done: %0d vectors, %0d errors", grp, nvec, error_count - err_start);
   endtask

   ////////////////////////////////////////
   // Receiver side
   ////////////////////////////////////////

   task automatic receive_results();
      fpu_defs_pkg::fpu_res_t expected;
      int due;
      int last_due;
      last_due = 0;
      forever begin
         @(negedge clk);
         if (res_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
               error_count++;
               $display("Result arrived with no request outstanding");
            end else begin
               expected = exp_q.pop_front();
               check_value("res.result", res.result, expected.result);
               check_value("res.flags", {28'h0, res.flags}, {28'h0, expected.flags});
               rcv_count++;
               // Random consumer delay with credits kept in order
               due = cycle + 1 + ({$random(seed)} % 8);
               if (due <= last_due) begin
                  due = last_due + 1;
               end
               last_due = due;
               credit_due.push_back(due);
            end
         end
      end
   endtask

   task automatic return_credits();
      forever begin
         @(posedge clk);
         cycle++;
         #2;
         if (credit_due.size() != 0 && credit_due[0] <= cycle) begin
            res_credit = 1'b1;
            void'(credit_due.pop_front());
         end else begin
            res_credit = 1'b0;
         end
      end
   endtask

   task automatic count_req_credits();
      forever begin
         @(negedge clk);
         if (req_credit === 1'b1) begin
            credit_back++;
            if (credit_back > sent_count) begin
               error_count++;
               $display("Request credit returned with no request outstanding");
            end
         end
      end
   endtask

   task automatic watchdog(int cycles);
      repeat (cycles) @(posedge clk);
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("Errors found");
      $finish;
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      bit         loaded;
      int         idx;
      int         grp;
      int         grp_vecs;
      int         grp_errors;
      logic [3:0] grp_flags;
      reset = 1'b1;
      req_valid = 1'b0;
      req = '0;
      res_credit = 1'b0;
      cfg_write = 1'b0;
      cfg_rm = fpu_defs_pkg::rm_rne;
      flags_clear = 1'b0;
      seed = 72;
      cycle = 0;
      sent_count = 0;
      rcv_count = 0;
      credit_back = 0;
      check_count = 0;
      error_count = 0;
      group_count = 0;
      load_vectors(loaded);
      if (!loaded || vec_group.size() == 0) begin
         $display("Could not read any vectors from verif/fpu_conv_vectors.txt");
         $display("Errors found");
         $finish;
      end else begin
         fork
            receive_results();
            return_credits();
            count_req_credits();
            watchdog(40 * vec_group.size() + 200);
         join_none
         repeat (4) @(posedge clk);
         #2;
         reset = 1'b0;
         idx = 0;
         while (idx < vec_group.size()) begin
            grp = vec_group[idx];
            grp_vecs = 0;
            grp_errors = error_count;
            grp_flags = '0;
            while (idx < vec_group.size() && vec_group[idx] == grp) begin
               if (vec_kind[idx] == 2) begin
                  write_mode(vec_operand[idx]);
               end else begin
                  send_request(idx);
                  grp_flags = grp_flags | vec_flags[idx];
                  grp_vecs++;
               end
               idx++;
            end
            finish_group(grp, grp_vecs, grp_flags, grp_errors);
         end
         // One req_credit pulse per request
         check_value("req_credit pulses", credit_back, sent_count);
         check_value("results received", rcv_count, sent_count);
         $display("Done: %0d groups, %0d requests, %0d checks, %0d errors",
                  group_count, sent_count, check_count, error_count);
         if (error_count == 0) begin
            $display("No errors");
         end else begin
            $display("Errors found");
         end
         $finish;
      end
   end

endmodule

// File: verif/fpu_conv_vectors.txt
# group op operand expected_result expected_flags, flags hex bits nv of zero ix
# rm line: operand 0 selects nearest-even, 1 toward zero, other fields unused
1 ftoi 3F400000 00000000 3
1 ftoi BF400000 00000000 3
1 ftoi 3FC00000 00000001 1
1 ftoi C0E80000 FFFFFFF9 1
1 ftoi 42F60000 0000007B 0
1 ftoi C2F60000 FFFFFF85 0
1 ftoi 4B000001 00800001 0
1 ftoi 4EFFFFFF 7FFFFF80 0
2 ftoi 4F000000 7FFFFFFF 5
2 ftoi CF000000 80000000 5
2 ftoi 7F800000 7FFFFFFF 5
2 ftoi FF800000 80000000 5
2 ftoi 7FC00000 7FFFFFFF D
2 ftoi FFC00001 80000000 D
2 ftoi 00000000 00000000 2
2 ftoi 00000001 00000000 3
3 itof 00000000 00000000 2
3 itof FFFFFFFF BF800000 0
3 itof 00FFFFFF 4B7FFFFF 0
3 itof 01000001 4B800000 1
3 itof 01000003 4B800002 1
3 itof 7FFFFFFF 4F000000 1
3 itof 80000000 CF000000 0
3 itof FEFFFFFD CB800002 1
4 rm 00000001 00000000 0
4 itof 00000000 00000000 2
4 itof FFFFFFFF BF800000 0
4 itof 00FFFFFF 4B7FFFFF 0
4 itof 01000001 4B800000 1
4 itof 01000003 4B800001 1
4 itof 7FFFFFFF 4EFFFFFF 1
4 itof 80000000 CF000000 0
4 itof FEFFFFFD CB800001 1
5 rm 00000000 00000000 0
5 ftoi 40490FDB 00000003 1
5 itof 00000003 40400000 0
5 ftoi C2C80000 FFFFFF9C 0
5 itof FFFFFF9C C2C80000 0
5 ftoi 3F000000 00000000 3
5 itof 00000400 44800000 0

// File: build.f
verilog/fpu_defs_pkg.sv
verilog/fpu_ftoi.sv
verilog/fpu_itof.sv
verilog/fpu_req_fifo.sv
verilog/fpu_cfg_regs.sv
verilog/fpu_conv_pipe.sv
verilog/fpu_conv_top.sv
verif/fpu_conv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the conversion unit testbench with Verilator
# Run from anywhere, paths resolve against the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fpu_conv_tb -f build.f -o fpu_conv_sim \
   > compile.log 2>&1 \
   && ./obj_dir/fpu_conv_sim > sim.log 2>&1 \
   || { cat compile.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
exit 0
